/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_apu_subsystem -f tb.f -o sim_apu

./obj_dir/sim_apu 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi

/* tb.f */
verilog/apu_reg_pkg.sv
verilog/apu_op_pkg.sv
verilog/apu_disp.sv
verilog/apu_issue_router.sv
verilog/apu_pipe_lane.sv
verilog/apu_result_merge.sv
verilog/apu_subsystem.sv
testbench/tb_apu_subsystem.sv

/* testbench/tb_apu_subsystem.sv */
// Runs directed and seeded random ops; register addresses stay in 0..7 so dependencies show up often

`timescale 1ns/1ps

module tb_apu_subsystem;

  localparam int unsigned SEED = 32'h44b22cbe;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      enable_i;
  apu_op_pkg::apu_op_e       op_i;
  apu_op_pkg::apu_data_t     opa_i, opb_i, opc_i;
  apu_reg_pkg::reg_addr_t    waddr_i;
  logic                      apu_gnt_i;
  logic                      is_decoding_i;
  apu_reg_pkg::read_addrs_t  read_regs_i;
  apu_reg_pkg::read_mask_t   read_regs_valid_i;
  apu_reg_pkg::write_addrs_t write_regs_i;
  apu_reg_pkg::write_mask_t  write_regs_valid_i;

  logic                      stall_o, active_o, read_dep_o, write_dep_o;
  logic                      perf_type_o, perf_cont_o, apu_multicycle_o, apu_singlecycle_o;
  logic                      result_valid_o;
  apu_op_pkg::apu_data_t     result_data_o;
  apu_reg_pkg::reg_addr_t    result_waddr_o;

  // Outstanding ops with the oldest first
  int unsigned               exp_due_q [$];
  apu_reg_pkg::reg_addr_t    exp_addr_q [$];
  apu_op_pkg::apu_data_t     exp_data_q [$];
  apu_op_pkg::apu_lat_t      last_lat;

  int unsigned               cycle_cnt;
  int unsigned               num_issued;

  apu_subsystem u_apu_subsystem (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_i),
    .op_i               (op_i),
    .opa_i              (opa_i),
    .opb_i              (opb_i),
    .opc_i              (opc_i),
    .waddr_i            (waddr_i),
    .apu_gnt_i          (apu_gnt_i),
    .is_decoding_i      (is_decoding_i),
    .read_regs_i        (read_regs_i),
    .read_regs_valid_i  (read_regs_valid_i),
    .write_regs_i       (write_regs_i),
    .write_regs_valid_i (write_regs_valid_i),
    .stall_o            (stall_o),
    .active_o           (active_o),
    .read_dep_o         (read_dep_o),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o),
    .apu_multicycle_o   (apu_multicycle_o),
    .apu_singlecycle_o  (apu_singlecycle_o),
    .result_valid_o     (result_valid_o),
    .result_data_o      (result_data_o),
    .result_waddr_o     (result_waddr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected result with the product taken at full width then cut
  function automatic apu_op_pkg::apu_data_t ref_result(input apu_op_pkg::apu_op_e op,
      input apu_op_pkg::apu_data_t a, input apu_op_pkg::apu_data_t b,
      input apu_op_pkg::apu_data_t c);
    logic [2*apu_op_pkg::DATA_W-1:0] full_prod;
    full_prod = {{apu_op_pkg::DATA_W{1'b0}}, a} * {{apu_op_pkg::DATA_W{1'b0}}, b};
    case (op)
      apu_op_pkg::OP_ADD: return a + b;
      apu_op_pkg::OP_SUB: return a - b;
      apu_op_pkg::OP_MUL: return full_prod[apu_op_pkg::DATA_W-1:0];
      default:            return full_prod[apu_op_pkg::DATA_W-1:0] + c;
    endcase
  endfunction

  // ADD and SUB one cycle, MUL two, MAC three
  function automatic apu_op_pkg::apu_lat_t op_class(input apu_op_pkg::apu_op_e op);
    case (op)
      apu_op_pkg::OP_ADD, apu_op_pkg::OP_SUB: return 2'd1;
      apu_op_pkg::OP_MUL:                     return 2'd2;
      default:                                return 2'd3;
    endcase
  endfunction

  function automatic logic read_hits(input apu_reg_pkg::reg_addr_t addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < apu_reg_pkg::NUM_READ_REGS; i++) begin
      if (read_regs_valid_i[i] && (read_regs_i[i] == addr)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic write_hits(input apu_reg_pkg::reg_addr_t addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < apu_reg_pkg::NUM_WRITE_REGS; i++) begin
      if (write_regs_valid_i[i] && (write_regs_i[i] == addr)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_data(input string name, input apu_op_pkg::apu_data_t exp,
      input apu_op_pkg::apu_data_t act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_addr(input string name, input apu_reg_pkg::reg_addr_t exp,
      input apu_reg_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "address mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  //////////////////////////////
  // Checking process
  //////////////////////////////

  // Sampled mid-cycle while inputs move 1 ns after the edge
  initial begin : compare_proc
    apu_op_pkg::apu_lat_t lat;
    logic exp_active, exp_ret, exp_full, exp_type, exp_req, exp_nack;
    logic exp_rdep, exp_wdep;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      if (cycle_cnt > 20 * num_issued + 100) begin
        $display("Timeout: no end of run after %0d cycles at time %0t", cycle_cnt, $time);
        $display("Result: FAILED");
        $fatal(1, "simulation timed out");
      end
      // Ops past their return cycle are gone
      while (exp_due_q.size() > 0 && exp_due_q[0] < cycle_cnt) begin
        exp_due_q.delete(0);
        exp_addr_q.delete(0);
        exp_data_q.delete(0);
      end
      lat        = op_class(op_i);
      exp_active = (exp_due_q.size() > 0);
      exp_ret    = exp_active && (exp_due_q[0] == cycle_cnt);
      exp_full   = (exp_due_q.size() == 2);
      // No overtaking; MUL may only follow ADD, SUB or MUL
      exp_type   = enable_i && exp_active &&
                   ((lat == 2'd1) || (lat == 2'd3) || ((lat == 2'd2) && (last_lat == 2'd3)));
      exp_req    = enable_i && !exp_full && !exp_type;
      exp_nack   = exp_req && !apu_gnt_i;

      // A slot in its return cycle is excluded
      exp_rdep = 1'b0;
      exp_wdep = 1'b0;
      for (int e = 0; e < exp_due_q.size(); e++) begin
        if (exp_due_q[e] > cycle_cnt) begin
          exp_rdep = exp_rdep | read_hits(exp_addr_q[e]);
          exp_wdep = exp_wdep | write_hits(exp_addr_q[e]);
        end
      end
      if (exp_req) begin
        exp_rdep = exp_rdep | read_hits(waddr_i);
        exp_wdep = exp_wdep | write_hits(waddr_i);
      end

      check_bit("stall_o", exp_full | exp_type | exp_nack, stall_o);
      check_bit("perf_type_o", exp_type, perf_type_o);
      check_bit("perf_cont_o", exp_nack, perf_cont_o);
      check_bit("active_o", exp_active, active_o);
      check_bit("apu_singlecycle_o", !exp_active, apu_singlecycle_o);
      check_bit("apu_multicycle_o", last_lat == 2'd3, apu_multicycle_o);
      check_bit("read_dep_o", is_decoding_i & exp_rdep, read_dep_o);
      check_bit("write_dep_o", is_decoding_i & exp_wdep, write_dep_o);
      check_bit("result_valid_o", exp_ret, result_valid_o);
      if (exp_ret) begin
        check_data("result_data_o", exp_data_q[0], result_data_o);
        check_addr("result_waddr_o", exp_addr_q[0], result_waddr_o);
      end

      // Accepted op returns lat cycles later
      if (exp_req && apu_gnt_i) begin
        exp_due_q.push_back(cycle_cnt + lat);
        exp_addr_q.push_back(waddr_i);
        exp_data_q.push_back(ref_result(op_i, opa_i, opb_i, opc_i));
      end
      if (exp_req) begin
        last_lat = lat;
      end
      cycle_cnt++;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic apu_reg_pkg::reg_addr_t rand_addr();
    return apu_reg_pkg::reg_addr_t'($urandom_range(7));
  endfunction

  function automatic apu_op_pkg::apu_op_e rand_op();
    return apu_op_pkg::apu_op_e'($urandom_range(3));
  endfunction

  // Decode-side registers change every cycle
  task automatic randomize_deps();
    is_decoding_i = ($urandom_range(1) == 1);
    for (int i = 0; i < apu_reg_pkg::NUM_READ_REGS; i++) begin
      read_regs_i[i] = rand_addr();
    end
    for (int i = 0; i < apu_reg_pkg::NUM_WRITE_REGS; i++) begin
      write_regs_i[i] = rand_addr();
    end
    read_regs_valid_i  = apu_reg_pkg::read_mask_t'($urandom);
    write_regs_valid_i = apu_reg_pkg::write_mask_t'($urandom);
  endtask

  // Starts 1 ns after an edge and holds the op until accepted
  task automatic issue_op(input apu_op_pkg::apu_op_e op, input apu_reg_pkg::reg_addr_t waddr,
      input int unsigned nack_cycles);
    int unsigned left;
    logic        accepted;
    left     = nack_cycles;
    accepted = 1'b0;
    num_issued++;
    enable_i = 1'b1;
    op_i     = op;
    opa_i    = $urandom;
    opb_i    = $urandom;
    opc_i    = $urandom;
    waddr_i  = waddr;
    while (!accepted) begin
      apu_gnt_i = (left == 0);
      if (left > 0) begin
        left--;
      end
      randomize_deps();
      #1;
      accepted = !stall_o;
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_idle();
    logic idle;
    idle      = 1'b0;
    enable_i  = 1'b0;
    apu_gnt_i = 1'b1;
    while (!idle) begin
      randomize_deps();
      #1;
      idle = !active_o;
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    cycle_cnt  = 0;
    num_issued = 0;
    last_lat   = '0;
    rst_ni     = 1'b0;
    enable_i   = 1'b0;
    op_i       = apu_op_pkg::OP_ADD;
    opa_i      = '0;
    opb_i      = '0;
    opc_i      = '0;
    waddr_i    = '0;
    apu_gnt_i  = 1'b1;
    is_decoding_i      = 1'b0;
    read_regs_i        = '0;
    read_regs_valid_i  = '0;
    write_regs_i       = '0;
    write_regs_valid_i = '0;

    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    #1;
    check_bit("result_valid_o", 1'b0, result_valid_o);
    check_bit("active_o", 1'b0, active_o);
    check_bit("apu_singlecycle_o", 1'b1, apu_singlecycle_o);
    @(posedge clk_i);
    #1;

    // Every opcode on its own
    for (int k = 0; k < 4; k++) begin
      issue_op(apu_op_pkg::apu_op_e'(k), rand_addr(), 0);
      wait_idle();
    end

    // Back-to-back streams
    repeat (8) issue_op(apu_op_pkg::OP_ADD, rand_addr(), 0);
    repeat (8) issue_op(apu_op_pkg::OP_SUB, rand_addr(), 0);
    repeat (8) issue_op(apu_op_pkg::OP_MUL, rand_addr(), 0);
    wait_idle();

    // Type conflicts behind MUL and MAC
    issue_op(apu_op_pkg::OP_MUL, rand_addr(), 0);
    issue_op(apu_op_pkg::OP_ADD, rand_addr(), 0);
    issue_op(apu_op_pkg::OP_MUL, rand_addr(), 0);
    issue_op(apu_op_pkg::OP_MAC, rand_addr(), 0);
    issue_op(apu_op_pkg::OP_MUL, rand_addr(), 0);
    wait_idle();

    // Grant withheld for random stretches
    repeat (20) issue_op(rand_op(), rand_addr(), $urandom_range(4));
    wait_idle();

    // Random mix, occasional missing grant
    repeat (200) issue_op(rand_op(), rand_addr(), ($urandom_range(3) == 0) ? $urandom_range(3) : 0);
    wait_idle();

    repeat (3) @(posedge clk_i);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* verilog/apu_disp.sv */
// Tracks at most two unreturned ops; a same-cycle return of a new request is never expected here

`timescale 1ns/1ps

module apu_disp (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Request from the core
  input  logic                        enable_i,
  input  apu_op_pkg::apu_lat_t        apu_lat_i,
  input  apu_reg_pkg::reg_addr_t      apu_waddr_i,

  // Handshake and return
  output logic                        apu_req_o,
  input  logic                        apu_gnt_i,
  input  logic                        apu_ret_valid_i,

  // Dependency checks for the op in decode
  input  logic                        is_decoding_i,
  input  apu_reg_pkg::read_addrs_t    read_regs_i,
  input  apu_reg_pkg::read_mask_t     read_regs_valid_i,
  input  apu_reg_pkg::write_addrs_t   write_regs_i,
  input  apu_reg_pkg::write_mask_t    write_regs_valid_i,

  output logic                        stall_o,
  output logic                        active_o,
  output apu_reg_pkg::reg_addr_t      apu_waddr_o,
  output logic                        apu_multicycle_o,
  output logic                        apu_singlecycle_o,
  output logic                        read_dep_o,
  output logic                        write_dep_o,
  output logic                        perf_type_o,
  output logic                        perf_cont_o
);

  apu_reg_pkg::reg_addr_t   addr_req, addr_inflight, addr_waiting;
  apu_reg_pkg::reg_addr_t   addr_inflight_d, addr_waiting_d;
  logic                     valid_req, valid_inflight, valid_waiting;
  logic                     valid_inflight_d, valid_waiting_d;
  logic                     ret_inflight, ret_waiting;
  logic                     req_accepted;
  logic                     active;
  apu_op_pkg::apu_lat_t     lat_q;

  apu_reg_pkg::read_mask_t  rdep_req, rdep_inflight, rdep_waiting;
  apu_reg_pkg::write_mask_t wdep_req, wdep_inflight, wdep_waiting;

  logic                     stall_full, stall_type, stall_nack;

  //////////////////////////////
  // Request and accept
  //////////////////////////////

  // Request unless full or type blocked; a missing grant still requests
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign addr_req     = apu_waddr_i;
  assign req_accepted = valid_req & apu_gnt_i;
  assign apu_req_o    = valid_req;

  // Return always hits the oldest outstanding op
  assign ret_inflight = valid_inflight & apu_ret_valid_i & ~valid_waiting;
  assign ret_waiting  = valid_waiting & apu_ret_valid_i;

  //////////////////////////////
  // In-flight and waiting slots
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight <= 1'b0;
      valid_waiting  <= 1'b0;
      addr_inflight  <= '0;
      addr_waiting   <= '0;
    end else begin
      valid_inflight <= valid_inflight_d;
      valid_waiting  <= valid_waiting_d;
      addr_inflight  <= addr_inflight_d;
      addr_waiting   <= addr_waiting_d;
    end
  end

  always_comb begin
    valid_inflight_d = valid_inflight;
    valid_waiting_d  = valid_waiting;
    addr_inflight_d  = addr_inflight;
    addr_waiting_d   = addr_waiting;
    if (req_accepted) begin
      // New op always takes the in-flight slot
      valid_inflight_d = 1'b1;
      addr_inflight_d  = addr_req;
      // Older op moves to waiting if it is still out
      if ((valid_inflight && !ret_inflight) || ret_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight;
      end
    end else if (ret_inflight) begin
      valid_inflight_d = 1'b0;
      valid_waiting_d  = 1'b0;
      addr_inflight_d  = '0;
      addr_waiting_d   = '0;
    end else if (ret_waiting) begin
      valid_waiting_d = 1'b0;
      addr_waiting_d  = '0;
    end
  end

  assign active = valid_inflight | valid_waiting;

  // Latency of the most recent request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= '0;
    end else if (valid_req) begin
      lat_q <= apu_lat_i;
    end
  end

  //////////////////////////////
  // Dependency checks
  //////////////////////////////

  for (genvar i = 0; i < apu_reg_pkg::NUM_READ_REGS; i++) begin : g_rdep
    assign rdep_req[i]      = (read_regs_i[i] == addr_req)      & read_regs_valid_i[i];
    assign rdep_inflight[i] = (read_regs_i[i] == addr_inflight) & read_regs_valid_i[i];
    assign rdep_waiting[i]  = (read_regs_i[i] == addr_waiting)  & read_regs_valid_i[i];
  end

  for (genvar i = 0; i < apu_reg_pkg::NUM_WRITE_REGS; i++) begin : g_wdep
    assign wdep_req[i]      = (write_regs_i[i] == addr_req)      & write_regs_valid_i[i];
    assign wdep_inflight[i] = (write_regs_i[i] == addr_inflight) & write_regs_valid_i[i];
    assign wdep_waiting[i]  = (write_regs_i[i] == addr_waiting)  & write_regs_valid_i[i];
  end

  // A slot in its return cycle no longer blocks
  assign read_dep_o = is_decoding_i & (
      (|rdep_req      & valid_req)                      |
      (|rdep_inflight & valid_inflight & ~ret_inflight) |
      (|rdep_waiting  & valid_waiting  & ~ret_waiting));

  assign write_dep_o = is_decoding_i & (
      (|wdep_req      & valid_req)                      |
      (|wdep_inflight & valid_inflight & ~ret_inflight) |
      (|wdep_waiting  & valid_waiting  & ~ret_waiting));

  //////////////////////////////
  // Stall rules
  //////////////////////////////

  assign stall_full = valid_inflight & valid_waiting;
  // Results must not overtake; only class 2 behind class 1 or 2 may overlap
  assign stall_type = enable_i & active & (
      (apu_lat_i == apu_op_pkg::LAT_SHORT) |
      ((apu_lat_i == apu_op_pkg::LAT_MID) & (lat_q == apu_op_pkg::LAT_MULTI)) |
      (apu_lat_i == apu_op_pkg::LAT_MULTI));
  assign stall_nack = valid_req & ~apu_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  //////////////////////////////
  // Write-back address
  //////////////////////////////

  // Later assignments win so the oldest slot goes last
  always_comb begin
    apu_waddr_o = '0;
    if (ret_inflight) begin
      apu_waddr_o = addr_inflight;
    end
    if (ret_waiting) begin
      apu_waddr_o = addr_waiting;
    end
  end

  assign active_o          = active;
  assign apu_multicycle_o  = (lat_q == apu_op_pkg::LAT_MULTI);
  assign apu_singlecycle_o = ~active;

  // Lanes must only return what was issued earlier
  a_ret_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
      apu_ret_valid_i |-> (valid_inflight | valid_waiting))
    else $error("apu_disp: result returned with nothing outstanding");

endmodule

/* verilog/apu_issue_router.sv */
// Purely combinational; starts a lane only on req and gnt both high; operand buses are shared

`timescale 1ns/1ps

module apu_issue_router (
  input  apu_op_pkg::apu_op_e                   op_i,
  input  apu_op_pkg::apu_data_t                 opa_i,
  input  apu_op_pkg::apu_data_t                 opb_i,
  input  apu_op_pkg::apu_data_t                 opc_i,
  input  logic                                  apu_req_i,
  input  logic                                  apu_gnt_i,

  output apu_op_pkg::apu_lat_t                  lat_o,
  output logic [apu_op_pkg::NUM_LANES-1:0]      lane_start_o,
  output apu_op_pkg::apu_op_e                   lane_op_o,
  output apu_op_pkg::apu_data_t                 lane_opa_o,
  output apu_op_pkg::apu_data_t                 lane_opb_o,
  output apu_op_pkg::apu_data_t                 lane_opc_o
);

  logic                  accept;
  apu_op_pkg::lane_idx_t lane_sel;

  // Class decode through the shared table
  assign lat_o = apu_op_pkg::op_latency(op_i);

  // Lane index is class minus one
  assign lane_sel = apu_op_pkg::lane_idx_t'(lat_o - 2'd1);
  assign accept   = apu_req_i & apu_gnt_i;

  //////////////////////////////
  // Lane steering
  //////////////////////////////

  always_comb begin
    lane_start_o = '0;
    for (int k = 0; k < apu_op_pkg::NUM_LANES; k++) begin
      if (accept && (lane_sel == apu_op_pkg::lane_idx_t'(k))) begin
        lane_start_o[k] = 1'b1;
      end
    end
  end

  // Lanes latch only on their own start strobe
  assign lane_op_o  = op_i;
  assign lane_opa_o = opa_i;
  assign lane_opb_o = opb_i;
  assign lane_opc_o = opc_i;

endmodule

/* verilog/apu_op_pkg.sv */
// Integer data only; latency class 0 is unused and class 3 only issues with nothing in flight

package apu_op_pkg;

  //////////////////////////////
  // Data path
  //////////////////////////////

  localparam int unsigned DATA_W = 32;

  // Operand or result word
  typedef logic [DATA_W-1:0] apu_data_t;

  //////////////////////////////
  // Operations
  //////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_MAC = 2'd3
  } apu_op_e;

  // Latency class, cycles from accept to result
  typedef logic [1:0] apu_lat_t;

  localparam apu_lat_t LAT_SHORT = 2'd1;
  localparam apu_lat_t LAT_MID   = 2'd2;
  // Multicycle class, never overlaps another op
  localparam apu_lat_t LAT_MULTI = 2'd3;

  // One lane per latency class, lane k is k+1 stages deep
  localparam int unsigned NUM_LANES = 3;

  typedef logic [1:0] lane_idx_t;

  // Opcode to latency class table
  function automatic apu_lat_t op_latency(apu_op_e op);
    case (op)
      OP_ADD:  return LAT_SHORT;
      OP_SUB:  return LAT_SHORT;
      OP_MUL:  return LAT_MID;
      default: return LAT_MULTI;
    endcase
  endfunction

endpackage

/* verilog/apu_pipe_lane.sv */
// Never stalls; DEPTH must be at least 1 and one op may enter every cycle

`timescale 1ns/1ps

module apu_pipe_lane #(
  parameter int unsigned DEPTH = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  start_i,
  input  apu_op_pkg::apu_op_e   op_i,
  input  apu_op_pkg::apu_data_t opa_i,
  input  apu_op_pkg::apu_data_t opb_i,
  input  apu_op_pkg::apu_data_t opc_i,

  output logic                  valid_o,
  output apu_op_pkg::apu_data_t result_o
);

  apu_op_pkg::apu_data_t calc;
  apu_op_pkg::apu_data_t prod;

  // Stage s holds result and valid of one op
  logic                  valid_q [DEPTH];
  apu_op_pkg::apu_data_t data_q  [DEPTH];

  //////////////////////////////
  // Arithmetic
  //////////////////////////////

  // Product truncated to the low word
  assign prod = opa_i * opb_i;

  always_comb begin
    case (op_i)
      apu_op_pkg::OP_ADD: calc = opa_i + opb_i;
      apu_op_pkg::OP_SUB: calc = opa_i - opb_i;
      apu_op_pkg::OP_MUL: calc = prod;
      default:            calc = prod + opc_i;
    endcase
  end

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  // First stage captures the finished result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q[0] <= 1'b0;
    end else begin
      valid_q[0] <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      data_q[0] <= calc;
    end
  end

  // Remaining stages only delay
  for (genvar s = 1; s < DEPTH; s++) begin : g_stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[s] <= 1'b0;
      end else begin
        valid_q[s] <= valid_q[s-1];
      end
    end

    always_ff @(posedge clk_i) begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign valid_o  = valid_q[DEPTH-1];
  assign result_o = data_q[DEPTH-1];

endmodule

/* verilog/apu_reg_pkg.sv */
// Register addresses are 6 bits wide; dependency checks cover 3 read ports and 2 write ports

package apu_reg_pkg;

  //////////////////////////////
  // Register address space
  //////////////////////////////

  localparam int unsigned REG_ADDR_W = 6;

  // Destination or source register address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Dependency check ports
  //////////////////////////////

  // Source operands of the instruction in decode
  localparam int unsigned NUM_READ_REGS  = 3;
  // Destinations of the instruction in decode
  localparam int unsigned NUM_WRITE_REGS = 2;

  // Address bundles, port 0 in the low slice
  typedef reg_addr_t [NUM_READ_REGS-1:0]  read_addrs_t;
  typedef reg_addr_t [NUM_WRITE_REGS-1:0] write_addrs_t;

  // One valid bit per checked port
  typedef logic [NUM_READ_REGS-1:0]  read_mask_t;
  typedef logic [NUM_WRITE_REGS-1:0] write_mask_t;

endpackage

/* verilog/apu_result_merge.sv */
// Assumes at most one lane returns per cycle; data is zero when no lane is valid

`timescale 1ns/1ps

module apu_result_merge (
  input  logic                             clk_i,

  input  logic [apu_op_pkg::NUM_LANES-1:0] lane_valid_i,
  input  apu_op_pkg::apu_data_t            lane_result_i [apu_op_pkg::NUM_LANES],

  output logic                             ret_valid_o,
  output apu_op_pkg::apu_data_t            ret_data_o
);

  //////////////////////////////
  // Write-back merge
  //////////////////////////////

  assign ret_valid_o = |lane_valid_i;

  // AND-OR select, valid lanes are one-hot
  always_comb begin
    ret_data_o = '0;
    for (int k = 0; k < apu_op_pkg::NUM_LANES; k++) begin
      if (lane_valid_i[k]) begin
        ret_data_o = ret_data_o | lane_result_i[k];
      end
    end
  end

  // The dispatcher type rule keeps lane returns apart
  a_ret_onehot : assert property (@(posedge clk_i) $onehot0(lane_valid_i))
    else $error("apu_result_merge: two lanes returned in one cycle");

endmodule

/* verilog/apu_subsystem.sv */
// Core must hold all request inputs while stall_o is high; no result back-pressure exists

`timescale 1ns/1ps

module apu_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Operation from the core
  input  logic                      enable_i,
  input  apu_op_pkg::apu_op_e       op_i,
  input  apu_op_pkg::apu_data_t     opa_i,
  input  apu_op_pkg::apu_data_t     opb_i,
  input  apu_op_pkg::apu_data_t     opc_i,
  input  apu_reg_pkg::reg_addr_t    waddr_i,

  // Grant from the shared unit arbiter
  input  logic                      apu_gnt_i,

  // Dependency checks
  input  logic                      is_decoding_i,
  input  apu_reg_pkg::read_addrs_t  read_regs_i,
  input  apu_reg_pkg::read_mask_t   read_regs_valid_i,
  input  apu_reg_pkg::write_addrs_t write_regs_i,
  input  apu_reg_pkg::write_mask_t  write_regs_valid_i,

  output logic                      stall_o,
  output logic                      active_o,
  output logic                      read_dep_o,
  output logic                      write_dep_o,
  output logic                      perf_type_o,
  output logic                      perf_cont_o,
  output logic                      apu_multicycle_o,
  output logic                      apu_singlecycle_o,

  // Write-back
  output logic                      result_valid_o,
  output apu_op_pkg::apu_data_t     result_data_o,
  output apu_reg_pkg::reg_addr_t    result_waddr_o
);

  apu_op_pkg::apu_lat_t             lat;
  logic                             apu_req;
  logic                             ret_valid;

  logic [apu_op_pkg::NUM_LANES-1:0] lane_start;
  apu_op_pkg::apu_op_e              lane_op;
  apu_op_pkg::apu_data_t            lane_opa, lane_opb, lane_opc;

  logic [apu_op_pkg::NUM_LANES-1:0] lane_valid;
  apu_op_pkg::apu_data_t            lane_data [apu_op_pkg::NUM_LANES];

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  apu_disp u_apu_disp (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_i),
    .apu_lat_i          (lat),
    .apu_waddr_i        (waddr_i),
    .apu_req_o          (apu_req),
    .apu_gnt_i          (apu_gnt_i),
    .apu_ret_valid_i    (ret_valid),
    .is_decoding_i      (is_decoding_i),
    .read_regs_i        (read_regs_i),
    .read_regs_valid_i  (read_regs_valid_i),
    .write_regs_i       (write_regs_i),
    .write_regs_valid_i (write_regs_valid_i),
    .stall_o            (stall_o),
    .active_o           (active_o),
    .apu_waddr_o        (result_waddr_o),
    .apu_multicycle_o   (apu_multicycle_o),
    .apu_singlecycle_o  (apu_singlecycle_o),
    .read_dep_o         (read_dep_o),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o)
  );

  // Class decode and lane select
  apu_issue_router u_apu_issue_router (
    .op_i         (op_i),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .opc_i        (opc_i),
    .apu_req_i    (apu_req),
    .apu_gnt_i    (apu_gnt_i),
    .lat_o        (lat),
    .lane_start_o (lane_start),
    .lane_op_o    (lane_op),
    .lane_opa_o   (lane_opa),
    .lane_opb_o   (lane_opb),
    .lane_opc_o   (lane_opc)
  );

  //////////////////////////////
  // Execution lanes
  //////////////////////////////

  // Lane k serves latency class k+1
  for (genvar k = 0; k < apu_op_pkg::NUM_LANES; k++) begin : g_lane
    apu_pipe_lane #(
      .DEPTH (k + 1)
    ) u_apu_pipe_lane (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .start_i  (lane_start[k]),
      .op_i     (lane_op),
      .opa_i    (lane_opa),
      .opb_i    (lane_opb),
      .opc_i    (lane_opc),
      .valid_o  (lane_valid[k]),
      .result_o (lane_data[k])
    );
  end

  apu_result_merge u_apu_result_merge (
    .clk_i         (clk_i),
    .lane_valid_i  (lane_valid),
    .lane_result_i (lane_data),
    .ret_valid_o   (ret_valid),
    .ret_data_o    (result_data_o)
  );

  // Return strobe also retires the dispatcher slot
  assign result_valid_o = ret_valid;

endmodule
